//--- compile.f
logic/regFilePkg.sv
logic/gprBankStore.sv
logic/sprReg.sv
logic/operandSelect.sv
logic/bypassNetwork.sv
logic/regFile6R3W.sv
verif/regFileTb.sv

//--- logic/bypassNetwork.sv
// Forwarding of in-flight EX1 to EX3 results onto one read port
`timescale 1ns/1ps
`default_nettype none

module bypassNetwork import regFilePkg::*;
(
	input  regId srcId,
	input  word  baseVal,
	input  logic bypassOk,
	input  regId fwdId [numStages][numLanes],  // Stage, then lane
	input  word  fwdVal [numStages][numLanes],
	output word  srcVal
);

	// Youngest result wins
	// Scan from EX3 lane C back to EX1 lane A, last hit sticks
	always_comb
	begin
		srcVal = baseVal;
		if (bypassOk)
		begin
			for (int stage = numStages - 1; stage >= 0; stage--)
			begin
				for (int lane = numLanes - 1; lane >= 0; lane--)
				begin
					if (fwdId[stage][lane] == srcId)  // Flushed slots still match
					begin
						srcVal = fwdVal[stage][lane];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/gprBankStore.sv
// Three-bank general register storage, live-value table, raw read ports
`timescale 1ns/1ps
`default_nettype none

module gprBankStore import regFilePkg::*;
#(
	parameter int numReadPorts = 6
)
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  logic wbFlush,
	input  regId wrId [numLanes],
	input  word  wrVal [numLanes],
	input  regId rdId [numReadPorts],
	output word  rdVal [numReadPorts]
);

	localparam int idxWidth = $clog2(gprCount);
	localparam int lvtWidth = $clog2(numLanes);

	word bank [numLanes][gprCount];  // One bank per write lane
	logic [lvtWidth-1:0] lvt [gprCount];  // Lane that last wrote each register
	logic commitEn;
	logic [numLanes-1:0] laneWr;

	assign commitEn = !hold && !wbFlush;

	// Only general registers land in the banks
	always_comb
	begin
		for (int lane = 0; lane < numLanes; lane++)
		begin
			laneWr[lane] = commitEn && !wrId[lane][regIdWidth-1];
		end
	end

	// Each lane owns its bank so writes never collide here
	always_ff @(posedge clock)
	begin
		for (int lane = 0; lane < numLanes; lane++)
		begin
			if (laneWr[lane])
			begin
				bank[lane][wrId[lane][idxWidth-1:0]] <= wrVal[lane];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int r = 0; r < gprCount; r++)
			begin
				lvt[r] <= '0;  // Everything points at bank A
			end
		end
		else
		begin
			// Later lanes overwrite earlier ones, so C beats B beats A
			for (int lane = 0; lane < numLanes; lane++)
			begin
				if (laneWr[lane])
				begin
					lvt[wrId[lane][idxWidth-1:0]] <= lvtWidth'(lane);
				end
			end
		end
	end

	// Raw bank fetch, decode of special IDs happens downstream
	always_comb
	begin
		for (int p = 0; p < numReadPorts; p++)
		begin
			rdVal[p] = bank[lvt[rdId[p][idxWidth-1:0]]][rdId[p][idxWidth-1:0]];
		end
	end

	// An X destination would corrupt the live-value table
	for (genvar lane = 0; lane < numLanes; lane++)
	begin : gWrIdCheck
		wrIdKnown: assert property (@(posedge clock) disable iff (rst)
			commitEn |-> !$isunknown(wrId[lane]));
	end

endmodule

`default_nettype wire

//--- logic/operandSelect.sv
// Source ID decode into bank value, special register, immediate or zero
`timescale 1ns/1ps
`default_nettype none

module operandSelect import regFilePkg::*;
(
	input  regId   srcId,
	input  word    bankVal,  // Raw bank fetch for this port
	input  word    dlrVal,
	input  word    spVal,
	input  immWord imm,  // Immediate of this port's lane
	output word    baseVal,
	output logic   bypassOk
);

	word immExt;

	assign immExt = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};

	always_comb
	begin
		baseVal = '0;
		bypassOk = 1'b1;
		if (!srcId[regIdWidth-1])
		begin
			baseVal = bankVal;  // General register
		end
		else
		begin
			case (srcId)
				idDlr:
				begin
					baseVal = dlrVal;
				end
				idSp:
				begin
					baseVal = spVal;
				end
				idImm:
				begin
					baseVal = immExt;
					bypassOk = 1'b0;  // Constants never come from the pipe
				end
				idZzr:
				begin
					baseVal = '0;
					bypassOk = 1'b0;
				end
				default:
				begin
					baseVal = '0;  // Unassigned IDs read as zero
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/regFile6R3W.sv
// Register file top with bank storage, DLR and SP, six read paths
`timescale 1ns/1ps
`default_nettype none

module regFile6R3W import regFilePkg::*;
#(
	parameter int numReadPorts = 6
)
(
	input  logic   clock,
	input  logic   rst,
	input  logic   hold,
	input  logic   wbFlush,  // Cancels the EX3 commit
	input  regId   srcId [numReadPorts],  // Rs, Rt, Ru, Rv, Rx, Ry
	input  immWord imm [numLanes],
	input  regId   fwdId [numStages][numLanes],
	input  word    fwdVal [numStages][numLanes],
	input  word    dlrIn,
	input  word    spIn,
	output word    srcVal [numReadPorts],
	output word    dlrOut,
	output word    spOut
);

	word  bankVal [numReadPorts];
	word  baseVal [numReadPorts];
	logic bypassOk [numReadPorts];
	word  dlrVal;
	word  spVal;

	// EX3 row doubles as the write ports
	gprBankStore #(
		.numReadPorts(numReadPorts)
	) u_gprBankStore (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.wbFlush(wbFlush),
		.wrId(fwdId[numStages-1]),
		.wrVal(fwdVal[numStages-1]),
		.rdId(srcId),
		.rdVal(bankVal)
	);

	sprReg #(
		.sprId(idDlr)
	) u_dlr (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.wbFlush(wbFlush),
		.wrId(fwdId[numStages-1]),
		.wrVal(fwdVal[numStages-1]),
		.extIn(dlrIn),
		.value(dlrVal)
	);

	sprReg #(
		.sprId(idSp)
	) u_sp (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.wbFlush(wbFlush),
		.wrId(fwdId[numStages-1]),
		.wrVal(fwdVal[numStages-1]),
		.extIn(spIn),
		.value(spVal)
	);

	assign dlrOut = dlrVal;
	assign spOut = spVal;

	// Ports 2k and 2k+1 belong to lane k
	for (genvar p = 0; p < numReadPorts; p++)
	begin : gReadPath
		operandSelect u_operandSelect (
			.srcId(srcId[p]),
			.bankVal(bankVal[p]),
			.dlrVal(dlrVal),
			.spVal(spVal),
			.imm(imm[p / 2]),
			.baseVal(baseVal[p]),
			.bypassOk(bypassOk[p])
		);

		bypassNetwork u_bypassNetwork (
			.srcId(srcId[p]),
			.baseVal(baseVal[p]),
			.bypassOk(bypassOk[p]),
			.fwdId(fwdId),
			.fwdVal(fwdVal),
			.srcVal(srcVal[p])
		);
	end

endmodule

`default_nettype wire

//--- logic/regFilePkg.sv
// Register file widths, word and ID types, special register ID encodings
`default_nettype none

package regFilePkg;

	localparam int dataWidth = 64;
	localparam int immWidth = 33;  // Bit 32 carries the sign
	localparam int regIdWidth = 6;
	localparam int gprCount = 32;  // IDs 0 to 31, bit 5 clear

	localparam int numLanes = 3;  // Lanes A, B, C
	localparam int numStages = 3;  // EX1, EX2, EX3

	typedef logic [dataWidth-1:0] word;
	typedef logic [regIdWidth-1:0] regId;
	typedef logic [immWidth-1:0] immWord;

	// Special sources above the general registers
	localparam regId idDlr = 6'd32;
	localparam regId idSp = 6'd33;
	localparam regId idImm = 6'd62;  // Lane immediate
	localparam regId idZzr = 6'd63;  // Zero, also the no-destination ID

endpackage

`default_nettype wire

//--- logic/sprReg.sv
// Special register with three-lane write priority and fallback input
`timescale 1ns/1ps
`default_nettype none

module sprReg import regFilePkg::*;
#(
	parameter regId sprId = idDlr
)
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  logic wbFlush,
	input  regId wrId [numLanes],
	input  word  wrVal [numLanes],
	input  word  extIn,  // Pipeline-supplied value
	output word  value
);

	word nextVal;

	// Walk C down to A so lane A ends up with priority
	always_comb
	begin
		nextVal = extIn;
		for (int lane = numLanes - 1; lane >= 0; lane--)
		begin
			if (wrId[lane] == sprId)
			begin
				nextVal = wrVal[lane];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			value <= '0;
		end
		else if (!hold && !wbFlush)
		begin
			value <= nextVal;
		end
	end

	holdFreezes: assert property (@(posedge clock) disable iff (rst)
		hold |=> $stable(value));

endmodule

`default_nettype wire

//--- verif/regFileInput.txt
# cmd idx(dec) b c(hex): fw/fr slot id val|tag, src pair idA idB, imm lane val, ctl 0 hold flush
# ext 0 dlrIn spIn, chk/chkr pair exp|tag exp|tag (pair 3 is dlrOut spOut), slot = stage*3+lane
fr 6 01 0	# Three lanes, three registers
fr 7 02 1
fr 8 03 2
step 0 0 0
clr 0 0 0
src 0 01 02
src 1 03 01
src 2 02 03
chkr 0 0 1
chkr 1 2 0
chkr 2 1 2
step 0 0 0
fw 6 05 aaaa	# Lanes A and C both write r5
fw 8 05 cccc
src 0 05 05
chk 0 aaaa aaaa
step 0 0 0
clr 0 0 0
chk 0 cccc cccc
fw 1 01 111	# r1 in EX1 B, EX2 A, EX3 A
fw 3 01 222
fw 6 01 333
fw 4 3e dead
ctl 0 1 0
imm 1 5 0
src 1 01 3e
chk 1 111 5
step 0 0 0
fw 1 3f 0
chk 1 222 5
step 0 0 0
fw 3 3f 0
chk 1 333 5
step 0 0 0
clr 0 0 0
src 1 01 01
chkr 1 0 0
imm 2 1fffffff0 0	# Negative immediate on lane C
src 2 3e 3e
src 0 3f 3f
chk 2 fffffffffffffff0 fffffffffffffff0
chk 0 0 0
fw 7 02 5555	# Held commit, then flushed commit
ctl 0 1 0
step 0 0 0
fw 7 3f 0
fw 8 03 6666
ctl 0 0 1
step 0 0 0
clr 0 0 0
src 0 02 03
chkr 0 1 2
ext 0 1234 5678	# Special registers
step 0 0 0
chk 3 1234 5678
fw 6 21 beef
ext 0 1234 9999
step 0 0 0
clr 0 0 0
src 0 21 21
chk 0 beef beef
chk 3 1234 beef
step 0 0 0

//--- verif/regFileTb.sv
// Testbench for the six-read three-write register file, driven by a vector file
`timescale 1ns/1ps
`default_nettype none

module regFileTb import regFilePkg::*;
();

	localparam int numPorts = 6;

	logic   clock;
	logic   rst;
	logic   hold;
	logic   wbFlush;
	regId   srcId [numPorts];
	immWord imm [numLanes];
	regId   fwdId [numStages][numLanes];
	word    fwdVal [numStages][numLanes];
	word    dlrIn;
	word    spIn;
	word    srcVal [numPorts];
	word    dlrOut;
	word    spOut;

	logic [8*8-1:0] cmdQ [$];  // Parsed vector lines
	int  idxQ [$];
	word bQ [$];
	word cQ [$];
	int  chkPair [$];  // Checks waiting for the next edge
	word chkExpA [$];
	word chkExpB [$];
	word rndVal [16];  // Random write values by tag
	int  stepCount = 0;
	int  cycleLimit = 0;
	int  cycleCount = 0;
	int  errCount = 0;

	regFile6R3W #(
		.numReadPorts(numPorts)
	) u_regFile6R3W (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.wbFlush(wbFlush),
		.srcId(srcId),
		.imm(imm),
		.fwdId(fwdId),
		.fwdVal(fwdVal),
		.dlrIn(dlrIn),
		.spIn(spIn),
		.srcVal(srcVal),
		.dlrOut(dlrOut),
		.spOut(spOut)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the vector run did not finish", cycleCount);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input word act, input word exp);
		assert (act === exp)
		else
		begin
			errCount++;
			$display("ERR time=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// Pair 3 is the special register outputs
	task automatic checkPair(input int k, input word expA, input word expB);
		if (k == 3)
		begin
			checkValue("dlrOut", dlrOut, expA);
			checkValue("spOut", spOut, expB);
		end
		else
		begin
			checkValue($sformatf("srcVal[%0d]", 2 * k), srcVal[2 * k], expA);
			checkValue($sformatf("srcVal[%0d]", 2 * k + 1), srcVal[2 * k + 1], expB);
		end
	endtask

	task automatic queueCheck(input int k, input word expA, input word expB);
		chkPair.push_back(k);
		chkExpA.push_back(expA);
		chkExpB.push_back(expB);
	endtask

	// Entered half a ns after an edge
	task automatic runStep();
		#3;
		while (chkPair.size() > 0)
		begin
			checkPair(chkPair.pop_front(), chkExpA.pop_front(), chkExpB.pop_front());
		end
		@(posedge clock);
		#0.5;
	endtask

	// No lane in flight, no hold, no flush
	task automatic clearPipe();
		for (int s = 0; s < numStages; s++)
		begin
			for (int l = 0; l < numLanes; l++)
			begin
				fwdId[s][l] = idZzr;
			end
		end
		hold = 1'b0;
		wbFlush = 1'b0;
	endtask

	task automatic loadVectors();
		int fd;
		int n;
		int a;
		word b;
		word c;
		logic [8*128-1:0] lineBuf;
		logic [8*8-1:0] cmd;
		fd = $fopen("verif/regFileInput.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the vector file verif/regFileInput.txt");
			$display("FAIL: see errors above");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			lineBuf = '0;
			n = $fgets(lineBuf, fd);
			n = $sscanf(lineBuf, "%s %d %h %h", cmd, a, b, c);
			if (n == 4)  // Comment and blank lines fall out here
			begin
				cmdQ.push_back(cmd);
				idxQ.push_back(a);
				bQ.push_back(b);
				cQ.push_back(c);
				if (cmd == "step")
				begin
					stepCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic applyCommand(input logic [8*8-1:0] cmd, input int a, input word b,
		input word c);
		word r;
		case (cmd)
			"fw":
			begin
				fwdId[a / 3][a % 3] = b[regIdWidth-1:0];
				fwdVal[a / 3][a % 3] = c;
			end
			"fr":
			begin
				r = {$urandom, $urandom};
				rndVal[c[3:0]] = r;  // Kept for later expectations
				fwdId[a / 3][a % 3] = b[regIdWidth-1:0];
				fwdVal[a / 3][a % 3] = r;
			end
			"src":
			begin
				srcId[2 * a] = b[regIdWidth-1:0];
				srcId[2 * a + 1] = c[regIdWidth-1:0];
			end
			"imm": imm[a] = b[immWidth-1:0];
			"ctl":
			begin
				hold = b[0];
				wbFlush = c[0];
			end
			"ext":
			begin
				dlrIn = b;
				spIn = c;
			end
			"clr": clearPipe();
			"step": runStep();
			"chk": queueCheck(a, b, c);
			"chkr": queueCheck(a, rndVal[b[3:0]], rndVal[c[3:0]]);
			default:
			begin
				$display("Unknown command in the vector file: %s", cmd);
				$display("FAIL: see errors above");
				$fatal(1);
			end
		endcase
	endtask

	initial
	begin
		clock = 1'b0;
		rst = 1'b1;
		dlrIn = '0;
		spIn = '0;
		for (int p = 0; p < numPorts; p++)
		begin
			srcId[p] = idZzr;
		end
		for (int l = 0; l < numLanes; l++)
		begin
			imm[l] = '0;
			for (int s = 0; s < numStages; s++)
			begin
				fwdVal[s][l] = {16{4'(3 * s + l + 1)}};  // Nonzero junk in idle slots
			end
		end
		clearPipe();
		void'($urandom(68));
		loadVectors();
		cycleLimit = 2 * stepCount + 50;
		repeat (8) @(posedge clock);
		#0.5;
		rst = 1'b0;
		for (int i = 0; i < cmdQ.size(); i++)
		begin
			applyCommand(cmdQ[i], idxQ[i], bQ[i], cQ[i]);
		end
		if (chkPair.size() > 0)
		begin
			runStep();  // Flush checks left after the last step
		end
		if (errCount == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
